//--- logic/conv_pkg.sv
package conv_pkg;

	// image and tile geometry
	localparam int img_dim       = 28;
	localparam int tile_dim      = 8;   // bank interleave tile
	localparam int lane_dim      = 4;   // 4x4 pixels per sram word
	localparam int tiles_per_row = 4;   // word address row stride

	localparam int ch_num = 4;
	localparam int taps   = 9;

	localparam int act_w      = 8;
	localparam int param_w    = 4;
	localparam int lanes      = 16;
	localparam int lane_idx_w = $clog2(lanes);
	localparam int bank_num   = 4;

	localparam int act_addr_w    = 6;
	localparam int weight_addr_w = 11;
	localparam int bias_addr_w   = 7;

	typedef enum logic [1:0] {
		st_idle,
		st_unshuffle,
		st_load_weight,
		st_done
	} layer_state_t;

	// one write to sram group a, strobes active low
	typedef struct packed {
		logic [bank_num-1:0]    wen;
		logic [act_addr_w-1:0]  waddr;
		logic [lanes-1:0]       bytemask;
		logic [lanes*act_w-1:0] wdata;
	} act_wr_t;

	// w[0][0] is the top-left tap and lands in the top nibble
	typedef struct packed {
		logic [0:2][0:2][param_w-1:0] w;
	} kernel_t;

	typedef kernel_t [0:ch_num-1] kernel_bank_t;

endpackage

//--- logic/layer_ctrl.sv
`timescale 1ns/1ps

module layer_ctrl import conv_pkg::*; (
	input  logic clk,
	input  logic rst_n,
	input  logic enable,
	input  logic scan_last,
	input  logic load_done,
	output logic pixel_take,
	output logic load_start,
	output logic busy,
	output logic layer_done,
	output logic kernel_valid
);

	layer_state_t state;
	layer_state_t state_nxt;

	// enable low just stalls the scan
	assign pixel_take = (state == st_unshuffle) && enable;
	assign busy       = (state == st_unshuffle) || (state == st_load_weight);
	assign layer_done = (state == st_done);

	always_comb begin
		state_nxt = state;
		unique case (state)
			st_idle: begin
				if (enable)
					state_nxt = st_unshuffle;   // this cycle takes no pixel
			end
			st_unshuffle: begin
				if (pixel_take && scan_last)
					state_nxt = st_load_weight;
			end
			st_load_weight: begin
				if (load_done)
					state_nxt = st_done;
			end
			st_done: begin
				state_nxt = st_idle;
			end
			default: begin
				state_nxt = st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state        <= st_idle;
			load_start   <= 1'b0;
			kernel_valid <= 1'b0;
		end else begin
			state      <= state_nxt;
			// pulse in the first cycle of st_load_weight
			load_start <= (state == st_unshuffle) && (state_nxt == st_load_weight);
			if (state == st_idle && enable)
				kernel_valid <= 1'b0;   // kernel goes stale once a new run starts
			else if (state == st_load_weight && load_done)
				kernel_valid <= 1'b1;
		end
	end

	// the writer may only flag the last pixel on a taken cycle
	a_last_on_take: assert property (@(posedge clk) disable iff (!rst_n)
		scan_last |-> pixel_take);

	// the loader must only finish while this fsm is waiting on it
	a_done_in_load: assert property (@(posedge clk) disable iff (!rst_n)
		load_done |-> state == st_load_weight);

endmodule

//--- logic/unshuffle_writer.sv
`timescale 1ns/1ps

module unshuffle_writer import conv_pkg::*; (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             pixel_take,
	input  logic [act_w-1:0] input_data,
	output logic             scan_last,
	output act_wr_t          act_wr
);

	logic [4:0] col_cnt;
	logic [4:0] row_cnt;
	logic       col_end;
	logic       row_end;

	logic                  col_hi;
	logic                  row_hi;
	logic [1:0]            bank;
	logic [lane_idx_w-1:0] lane;
	logic [act_addr_w-1:0] waddr_nxt;

	logic [bank_num-1:0]    wen_q;
	logic [lanes-1:0]       mask_q;
	logic [act_addr_w-1:0]  waddr_q;
	logic [lanes*act_w-1:0] wdata_q;

	assign col_end   = (col_cnt == 5'(img_dim - 1));
	assign row_end   = (row_cnt == 5'(img_dim - 1));
	assign scan_last = pixel_take && col_end && row_end;   // pixel 783

	// scan position wraps back to zero after the last pixel
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (pixel_take) begin
			col_cnt <= col_end ? 5'd0 : col_cnt + 5'd1;
			if (col_end)
				row_cnt <= row_end ? 5'd0 : row_cnt + 5'd1;
		end
	end

	// second half of the tile in either direction picks the bank
	assign col_hi = (col_cnt % tile_dim) >= lane_dim;
	assign row_hi = (row_cnt % tile_dim) >= lane_dim;
	assign bank   = {row_hi, col_hi};

	assign lane = lane_idx_w'((row_cnt % lane_dim) * lane_dim + (col_cnt % lane_dim));
	assign waddr_nxt = act_addr_w'((row_cnt / tile_dim) * tiles_per_row
		+ (col_cnt / tile_dim));

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wen_q  <= '1;
			mask_q <= '1;
		end else if (pixel_take) begin
			wen_q  <= ~(bank_num'(1) << bank);
			mask_q <= ~(lanes'(1) << lane);
		end else begin
			wen_q  <= '1;   // no write on a stall
			mask_q <= '1;
		end
	end

	always_ff @(posedge clk) begin
		if (pixel_take) begin
			waddr_q <= waddr_nxt;
			wdata_q <= {lanes{input_data}};   // replicated in every lane while the mask picks one
		end
	end

	assign act_wr = '{wen: wen_q, waddr: waddr_q, bytemask: mask_q, wdata: wdata_q};

	a_scan_range: assert property (@(posedge clk) disable iff (!rst_n)
		col_cnt < img_dim && row_cnt < img_dim);

endmodule

//--- logic/weight_loader.sv
`timescale 1ns/1ps

module weight_loader import conv_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     load_start,
	input  logic [taps*param_w-1:0]  sram_rdata_weight,
	output logic [weight_addr_w-1:0] sram_raddr_weight,
	output logic [bias_addr_w-1:0]   sram_raddr_bias,
	output kernel_bank_t             kernel,
	output logic                     load_done
);

	logic       rd_active;   // address phase, one word per cycle
	logic [1:0] rd_cnt;
	logic       cap_active;  // data phase, one cycle behind
	logic [1:0] cap_ch;

	// the address only moves forward, so run n reads 4n to 4n+3
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_active         <= 1'b0;
			rd_cnt            <= '0;
			sram_raddr_weight <= '0;
			sram_raddr_bias   <= '0;
		end else if (load_start) begin
			rd_active       <= 1'b1;
			rd_cnt          <= '0;
			sram_raddr_bias <= sram_raddr_weight[2 +: bias_addr_w];   // kernel group index
		end else if (rd_active) begin
			sram_raddr_weight <= sram_raddr_weight + 1'b1;
			rd_cnt            <= rd_cnt + 2'd1;
			if (rd_cnt == 2'(ch_num - 1))
				rd_active <= 1'b0;
		end
	end

	// sram answers one cycle after the address
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cap_active <= 1'b0;
			cap_ch     <= '0;
		end else begin
			cap_active <= rd_active;
			cap_ch     <= rd_cnt;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			kernel <= '0;
		else if (cap_active)
			kernel[cap_ch] <= kernel_t'(sram_rdata_weight);
	end

	assign load_done = cap_active && (cap_ch == 2'(ch_num - 1));   // fourth word

	a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
		load_start |-> !(rd_active || cap_active));

endmodule

//--- logic/conv_top.sv
`timescale 1ns/1ps

module conv_top import conv_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     enable,
	input  logic [act_w-1:0]         input_data,
	input  logic [taps*param_w-1:0]  sram_rdata_weight,

	output act_wr_t                  act_wr,       // sram group a write port
	output logic [weight_addr_w-1:0] sram_raddr_weight,
	output logic [bias_addr_w-1:0]   sram_raddr_bias,
	output kernel_bank_t             kernel,       // to the conv array
	output logic                     kernel_valid,
	output logic                     busy,
	output logic                     layer_done
);

	logic pixel_take;
	logic scan_last;
	logic load_start;
	logic load_done;

	layer_ctrl ctrl_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.enable       (enable),
		.scan_last    (scan_last),
		.load_done    (load_done),
		.pixel_take   (pixel_take),
		.load_start   (load_start),
		.busy         (busy),
		.layer_done   (layer_done),
		.kernel_valid (kernel_valid)
	);

	// image scatter into the four activation banks
	unshuffle_writer unshuffle_i (
		.clk        (clk),
		.rst_n      (rst_n),
		.pixel_take (pixel_take),
		.input_data (input_data),
		.scan_last  (scan_last),
		.act_wr     (act_wr)
	);

	weight_loader weight_i (
		.clk               (clk),
		.rst_n             (rst_n),
		.load_start        (load_start),
		.sram_rdata_weight (sram_rdata_weight),
		.sram_raddr_weight (sram_raddr_weight),
		.sram_raddr_bias   (sram_raddr_bias),
		.kernel            (kernel),
		.load_done         (load_done)
	);

endmodule

//--- bench/conv_checker.sv
`timescale 1ns/1ps

module conv_checker import conv_pkg::*; (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     enable,
	input  logic [act_w-1:0]         input_data,
	input  act_wr_t                  act_wr,
	input  logic [weight_addr_w-1:0] sram_raddr_weight,
	input  logic [bias_addr_w-1:0]   sram_raddr_bias,
	input  kernel_bank_t             kernel,
	input  logic                     kernel_valid,
	input  logic                     busy,
	input  logic                     layer_done,
	input  logic [7:0]               run_id,
	input  logic [bias_addr_w-1:0]   exp_bias,
	input  logic [weight_addr_w-1:0] exp_waddr,
	output int                       n_tests,
	output int                       n_bad_tests,
	output int                       n_checks,
	output int                       n_errors
);

	localparam int pixels   = img_dim * img_dim;
	localparam int done_cyc = 6;   // load_start to layer_done

	logic reset_checked;
	logic in_load;
	int   load_cyc;   // 0 is the cycle that carries load_start
	int   taken;
	int   writes;
	int   test_errs;
	int   row;
	int   col;

	// write owed for the pixel taken one cycle earlier
	logic                  pend;
	logic [1:0]            pend_bank;
	logic [act_addr_w-1:0] pend_waddr;
	logic [lane_idx_w-1:0] pend_lane;
	logic [act_w-1:0]      pend_pixel;

	// same word as the weight sram model in the testbench
	function automatic logic [taps*param_w-1:0] weight_word(input logic [weight_addr_w-1:0] a);
		return {a ^ 11'h2c5, 1'b0, a + 11'd3, 1'b1, ~a, 1'b0};
	endfunction

	// tap 0 comes from the top nibble, taps run row by row
	function automatic kernel_bank_t expected_kernel(input logic [weight_addr_w-1:0] first);
		kernel_bank_t            k;
		logic [taps*param_w-1:0] word;
		k = '0;
		for (int ch = 0; ch < ch_num; ch++) begin
			word = weight_word(first + weight_addr_w'(ch));
			for (int t = 0; t < taps; t++)
				k[ch].w[t / 3][t % 3] = word[(taps - 1 - t) * param_w +: param_w];
		end
		return k;
	endfunction

	task automatic expect_true(input bit ok, input string msg);
		n_checks++;
		if (!ok) begin
			n_errors++;
			test_errs++;
			$display("[FAIL] %0t: %s", $time, msg);
		end
	endtask

	task automatic finish_test(input string name);
		n_tests++;
		if (test_errs == 0) begin
			$display("%s: ok", name);
		end else begin
			n_bad_tests++;
			$display("%s: %0d errors", name, test_errs);
		end
		test_errs = 0;
	endtask

	task automatic check_reset();
		expect_true(act_wr.wen == '1, "wen not idle after reset");
		expect_true(act_wr.bytemask == '1, "bytemask not idle after reset");
		expect_true(!busy && !layer_done && !kernel_valid, "status high after reset");
		expect_true(kernel == '0, "kernel not cleared by reset");
		expect_true(sram_raddr_weight == '0 && sram_raddr_bias == '0,
			"sram addresses not zero after reset");
		finish_test("reset");
	endtask

	task automatic check_write();
		if (act_wr.wen != '1)
			writes++;
		if (pend) begin
			expect_true(act_wr.wen == ~(bank_num'(1) << pend_bank),
				$sformatf("pixel %0d wen %b, bank %0d expected", taken - 1, act_wr.wen, pend_bank));
			expect_true(act_wr.waddr == pend_waddr,
				$sformatf("pixel %0d waddr %0d, expected %0d", taken - 1, act_wr.waddr, pend_waddr));
			expect_true(act_wr.bytemask == ~(lanes'(1) << pend_lane),
				$sformatf("pixel %0d bytemask %h, lane %0d expected", taken - 1,
				act_wr.bytemask, pend_lane));
			expect_true(act_wr.wdata == {lanes{pend_pixel}},
				$sformatf("pixel %0d wdata %h, pixel %h", taken - 1, act_wr.wdata, pend_pixel));
		end else begin
			expect_true(act_wr.wen == '1, $sformatf("write strobe %b with no pixel taken",
				act_wr.wen));
		end
	endtask

	task automatic take_pixel();
		row        = taken / img_dim;
		col        = taken % img_dim;
		pend       = 1'b1;
		pend_bank  = 2'(((row % tile_dim) >= lane_dim ? 2 : 0)
			+ ((col % tile_dim) >= lane_dim ? 1 : 0));
		pend_waddr = act_addr_w'((row / tile_dim) * tiles_per_row + col / tile_dim);
		pend_lane  = lane_idx_w'((row % lane_dim) * lane_dim + col % lane_dim);
		pend_pixel = input_data;
		expect_true(!kernel_valid, "kernel_valid high during the scan");
		taken++;
		if (taken == pixels) begin
			in_load  = 1'b1;
			load_cyc = 0;
		end
	endtask

	task automatic step_load();
		if (load_cyc >= 1 && load_cyc <= ch_num)
			expect_true(sram_raddr_weight == exp_waddr + weight_addr_w'(load_cyc - 1),
				$sformatf("weight address %0d in load cycle %0d", sram_raddr_weight, load_cyc));
		if (load_cyc < done_cyc) begin
			expect_true(busy, "busy low during the weight load");
			expect_true(!layer_done, $sformatf("layer_done in load cycle %0d", load_cyc));
			expect_true(!kernel_valid, "kernel_valid high before layer_done");
			load_cyc++;
		end else begin
			expect_true(layer_done, "layer_done missing six cycles after load_start");
			expect_true(!busy, "busy still high with layer_done");
			expect_true(kernel_valid, "kernel_valid low with layer_done");
			expect_true(kernel == expected_kernel(exp_waddr),
				$sformatf("kernel %h, expected %h", kernel, expected_kernel(exp_waddr)));
			expect_true(sram_raddr_bias == exp_bias,
				$sformatf("bias address %0d, expected %0d", sram_raddr_bias, exp_bias));
			expect_true(writes == pixels, $sformatf("%0d writes in the run", writes));
			finish_test($sformatf("run %0d (bias %0d, weights from %0d)", run_id, exp_bias,
				exp_waddr));
			taken   = 0;
			writes  = 0;
			in_load = 1'b0;
		end
	endtask

	// samples at the edge, so every value belongs to the cycle just ended
	always @(posedge clk) begin
		if (!rst_n) begin
			reset_checked = 1'b0;
			in_load       = 1'b0;
			load_cyc      = 0;
			taken         = 0;
			writes        = 0;
			test_errs     = 0;
			pend          = 1'b0;
			n_tests       = 0;
			n_bad_tests   = 0;
			n_checks      = 0;
			n_errors      = 0;
		end else begin
			if (!reset_checked) begin
				check_reset();
				reset_checked = 1'b1;
			end
			check_write();
			pend = 1'b0;
			if (in_load) begin
				step_load();
			end else begin
				expect_true(!layer_done, "layer_done outside the weight load");
				if (busy && enable)
					take_pixel();
			end
		end
	end

endmodule

//--- bench/conv_tb.sv
`timescale 1ns/1ps

module conv_tb import conv_pkg::*; ();

	typedef struct packed {
		logic [7:0]               run;
		logic [7:0]               stall_k;       // enable low every k-th cycle, 0 for none
		logic [bias_addr_w-1:0]   bias;
		logic [weight_addr_w-1:0] first_waddr;
	} run_row_t;

	localparam int num_rows   = 3;
	localparam int max_cycles = num_rows * (img_dim * img_dim * 2 + 50);

	logic                     clk;
	logic                     rst_n;
	logic                     enable;
	logic [act_w-1:0]         input_data;
	logic [taps*param_w-1:0]  sram_rdata_weight = '0;
	act_wr_t                  act_wr;
	logic [weight_addr_w-1:0] sram_raddr_weight;
	logic [bias_addr_w-1:0]   sram_raddr_bias;
	kernel_bank_t             kernel;
	logic                     kernel_valid;
	logic                     busy;
	logic                     layer_done;

	logic [7:0]               run_id;
	logic [bias_addr_w-1:0]   exp_bias;
	logic [weight_addr_w-1:0] exp_waddr;
	int                       n_tests;
	int                       n_bad_tests;
	int                       n_checks;
	int                       n_errors;

	run_row_t    run_table [0:num_rows-1];
	logic [31:0] rnd;
	int          cyc;
	logic        done_seen;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic logic [taps*param_w-1:0] weight_word(input logic [weight_addr_w-1:0] a);
		return {a ^ 11'h2c5, 1'b0, a + 11'd3, 1'b1, ~a, 1'b0};
	endfunction

	function automatic logic enable_level(input int k, input int n);
		if (k == 0)
			return 1'b1;
		return (n % k) != (k - 1);
	endfunction

	conv_top dut_i (
		.clk               (clk),
		.rst_n             (rst_n),
		.enable            (enable),
		.input_data        (input_data),
		.sram_rdata_weight (sram_rdata_weight),
		.act_wr            (act_wr),
		.sram_raddr_weight (sram_raddr_weight),
		.sram_raddr_bias   (sram_raddr_bias),
		.kernel            (kernel),
		.kernel_valid      (kernel_valid),
		.busy              (busy),
		.layer_done        (layer_done)
	);

	conv_checker check_i (
		.clk               (clk),
		.rst_n             (rst_n),
		.enable            (enable),
		.input_data        (input_data),
		.act_wr            (act_wr),
		.sram_raddr_weight (sram_raddr_weight),
		.sram_raddr_bias   (sram_raddr_bias),
		.kernel            (kernel),
		.kernel_valid      (kernel_valid),
		.busy              (busy),
		.layer_done        (layer_done),
		.run_id            (run_id),
		.exp_bias          (exp_bias),
		.exp_waddr         (exp_waddr),
		.n_tests           (n_tests),
		.n_bad_tests       (n_bad_tests),
		.n_checks          (n_checks),
		.n_errors          (n_errors)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
		sram_rdata_weight <= weight_word(sram_raddr_weight);   // one cycle read latency

	initial begin
		repeat (max_cycles) @(posedge clk);
		$display("watchdog expired, the runs did not finish within %0d cycles", max_cycles);
		$display("sim failed");
		$finish;
	end

	initial begin
		run_table[0] = '{run: 8'd0, stall_k: 8'd0, bias: 7'd0, first_waddr: 11'd0};
		run_table[1] = '{run: 8'd1, stall_k: 8'd3, bias: 7'd1, first_waddr: 11'd4};
		run_table[2] = '{run: 8'd2, stall_k: 8'd5, bias: 7'd2, first_waddr: 11'd8};
		rnd        = 32'd92;
		rst_n      = 1'b0;
		enable     = 1'b0;
		input_data = '0;
		run_id     = '0;
		exp_bias   = '0;
		exp_waddr  = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		repeat (3) @(posedge clk);

		for (int r = 0; r < num_rows; r++) begin
			run_id    <= run_table[r].run;
			exp_bias  <= run_table[r].bias;
			exp_waddr <= run_table[r].first_waddr;
			cyc       = 0;
			done_seen = 1'b0;
			while (!done_seen) begin
				@(posedge clk);
				if (layer_done) begin
					done_seen = 1'b1;
				end else begin
					rnd        = lcg_next(rnd);
					enable     <= enable_level(int'(run_table[r].stall_k), cyc);
					input_data <= rnd[23:16];
					cyc++;
				end
			end
			enable <= 1'b0;
			repeat (3) @(posedge clk);
		end

		repeat (2) @(posedge clk);
		$display("tests %0d, with errors %0d, checks %0d, mismatches %0d",
			n_tests, n_bad_tests, n_checks, n_errors);
		if (n_tests != num_rows + 1)
			$display("only %0d of %0d tests reached their end", n_tests, num_rows + 1);
		if (n_errors == 0 && n_tests == num_rows + 1)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

//--- tb.f
logic/conv_pkg.sv
logic/layer_ctrl.sv
logic/unshuffle_writer.sv
logic/weight_loader.sv
logic/conv_top.sv
bench/conv_checker.sv
bench/conv_tb.sv

//--- Makefile
# Verilator build and run of the convolution front end testbench

VERILATOR ?= verilator
TOP       ?= conv_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= tb.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) | tee $(LOG)
	@grep -q "sim passed" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
